//--- hw/branch_pkg.sv
package branch_pkg;

  typedef logic [31:0] word_t;

  // Decoded compare kind for conditional branches
  typedef enum logic [2:0] {
    BT_BEQ,
    BT_BNE,
    BT_BLT,
    BT_BGE,
    BT_BLTU,
    BT_BGEU
  } branch_type_t;

  // J_NONE marks a conditional branch
  typedef enum logic [1:0] {
    J_NONE,
    J_JAL,
    J_JALR
  } jump_type_t;

  // 2 and 3 predict taken
  typedef logic [1:0] counter_t;

  localparam counter_t CTR_ALLOC = 2'd2;

  // Index width the entry layout is sized for. Wider indexes leave high tag bits at zero
  localparam int BTB_DEF_INDEX_BITS = 4;
  localparam int BTB_TAG_MAX = 30 - BTB_DEF_INDEX_BITS;

  typedef logic [BTB_TAG_MAX-1:0] btb_tag_t;

  typedef struct packed {
    logic     valid;
    btb_tag_t tag;
    word_t    target;
    counter_t ctr;
  } btb_entry_t;

  typedef enum logic {
    LK_IDLE,
    LK_WAIT
  } lookup_state_t;

  // PC bits above the index and the byte offset, zero extended
  function automatic btb_tag_t btb_tag(word_t pc, int unsigned index_bits);
    return btb_tag_t'(pc >> (index_bits + 2));
  endfunction

endpackage

//--- hw/fu_branch_if.sv
interface fu_branch_if
  import branch_pkg::*;
();

  // Decoded branch or jump from issue
  logic         enable;
  jump_type_t   j_type;
  branch_type_t branch_type;
  word_t        reg_a;
  word_t        reg_b;
  word_t        imm;
  word_t        current_pc;
  logic         predicted_outcome;

  // Resolution results
  logic         branch_outcome;
  logic         miss;
  word_t        correct_pc;
  word_t        branch_target;
  logic         resolved;
  word_t        jump_wdat;

  // One strobe per resolved conditional branch
  logic         update_btb;
  word_t        update_pc;

  modport br (
    input  enable, j_type, branch_type, reg_a, reg_b, imm, current_pc, predicted_outcome,
    output branch_outcome, miss, correct_pc, branch_target, resolved, jump_wdat,
    output update_btb, update_pc
  );

  modport top (
    output enable, j_type, branch_type, reg_a, reg_b, imm, current_pc, predicted_outcome,
    input  branch_outcome, miss, correct_pc, branch_target, resolved, jump_wdat,
    input  update_btb, update_pc
  );

endinterface

//--- hw/btb_port_if.sv
interface btb_port_if
  import branch_pkg::*;
();

  // The arbiter derives index and tag from pc
  logic       req;
  logic       we;
  word_t      pc;
  logic       taken;
  word_t      target;

  logic       gnt;
  // Entry read, valid the cycle after gnt
  btb_entry_t rdata;

  modport peer (
    output req, we, pc, taken, target,
    input  gnt, rdata
  );

  modport arb (
    input  req, we, pc, taken, target,
    output gnt, rdata
  );

endinterface

//--- hw/fu_branch.sv
module fu_branch
  import branch_pkg::*;
(
  input logic     CLK,
  input logic     nRST,
  fu_branch_if.br fubif
);

  logic  is_branch;
  logic  eq;
  logic  lt;
  logic  ltu;
  logic  taken;
  logic  seen_last;
  logic  last_valid;
  word_t last_pc;
  word_t pc_plus4;
  word_t pc_plus_imm;
  word_t jalr_dest;

  assign is_branch   = fubif.enable && (fubif.j_type == J_NONE);
  assign pc_plus4    = fubif.current_pc + 32'd4;
  assign pc_plus_imm = fubif.current_pc + fubif.imm;
  // JALR drops bit 0 of the sum
  assign jalr_dest   = (fubif.reg_a + fubif.imm) & ~32'd1;

  // Same branch still sitting on the port from last cycle
  assign seen_last = last_valid && (last_pc == fubif.current_pc);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      last_valid <= 1'b0;
      last_pc    <= '0;
    end else begin
      last_valid <= is_branch;
      if (is_branch) begin
        last_pc <= fubif.current_pc;
      end
    end
  end

  assign eq  = (fubif.reg_a == fubif.reg_b);
  assign lt  = ($signed(fubif.reg_a) < $signed(fubif.reg_b));
  assign ltu = (fubif.reg_a < fubif.reg_b);

  // NE, GE and GEU are the inverted forms
  always_comb begin
    case (fubif.branch_type)
      BT_BEQ:  taken = eq;
      BT_BNE:  taken = !eq;
      BT_BLT:  taken = lt;
      BT_BGE:  taken = !lt;
      BT_BLTU: taken = ltu;
      BT_BGEU: taken = !ltu;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    fubif.branch_outcome = 1'b0;
    fubif.miss           = 1'b0;
    fubif.correct_pc     = pc_plus4;
    fubif.branch_target  = '0;
    fubif.resolved       = 1'b0;
    fubif.jump_wdat      = '0;
    fubif.update_btb     = 1'b0;
    fubif.update_pc      = '0;

    if (fubif.enable) begin
      case (fubif.j_type)
        J_JAL: begin
          fubif.branch_outcome = 1'b1;
          fubif.branch_target  = pc_plus_imm;
          fubif.correct_pc     = pc_plus_imm;
          fubif.resolved       = 1'b1;
          fubif.jump_wdat      = pc_plus4;
        end
        J_JALR: begin
          fubif.branch_outcome = 1'b1;
          fubif.branch_target  = jalr_dest;
          fubif.correct_pc     = jalr_dest;
          fubif.resolved       = 1'b1;
          fubif.jump_wdat      = pc_plus4;
        end
        J_NONE: begin
          fubif.branch_outcome = taken;
          fubif.branch_target  = pc_plus_imm;
          fubif.correct_pc     = taken ? pc_plus_imm : pc_plus4;
          fubif.miss           = (taken != fubif.predicted_outcome);
          fubif.resolved       = (taken == fubif.predicted_outcome);
          // Held branches strobe only in their first cycle
          fubif.update_btb     = !seen_last;
          fubif.update_pc      = fubif.current_pc;
        end
        default: begin
          fubif.correct_pc = pc_plus4;
        end
      endcase
    end
  end

endmodule

//--- hw/btb_lookup.sv
module btb_lookup
  import branch_pkg::*;
#(
  parameter int BTB_INDEX_BITS = BTB_DEF_INDEX_BITS
) (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        fetch_req,
  input  word_t       fetch_pc,
  btb_port_if.peer    lk,
  output logic        pred_valid,
  output logic        pred_taken,
  output word_t       pred_target
);

  lookup_state_t state;
  lookup_state_t state_next;
  word_t         pc_q;
  logic          rd_pend;
  logic          hit;

  always_comb begin
    state_next = state;
    case (state)
      LK_IDLE: if (fetch_req) state_next = LK_WAIT;
      LK_WAIT: if (lk.gnt) state_next = LK_IDLE;
      default: state_next = LK_IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state   <= LK_IDLE;
      rd_pend <= 1'b0;
    end else begin
      state   <= state_next;
      rd_pend <= lk.gnt;
    end
  end

  // Fetch PC is only taken in while idle
  always_ff @(posedge CLK) begin
    if (state == LK_IDLE && fetch_req) begin
      pc_q <= fetch_pc;
    end
  end

  // Read-only peer
  assign lk.req    = (state == LK_WAIT);
  assign lk.we     = 1'b0;
  assign lk.pc     = pc_q;
  assign lk.taken  = 1'b0;
  assign lk.target = '0;

  assign hit = lk.rdata.valid && (lk.rdata.tag == btb_tag(pc_q, BTB_INDEX_BITS));

  // Counter MSB set means weakly or strongly taken
  assign pred_valid  = rd_pend;
  assign pred_taken  = rd_pend && hit && lk.rdata.ctr[1];
  assign pred_target = pred_taken ? lk.rdata.target : pc_q + 32'd4;

endmodule

//--- hw/btb_arbiter.sv
module btb_arbiter
  import branch_pkg::*;
#(
  parameter int BTB_INDEX_BITS = BTB_DEF_INDEX_BITS
) (
  input  logic                      CLK,
  input  logic                      nRST,
  btb_port_if.arb                   upd,
  btb_port_if.arb                   lk,
  output logic                      en,
  output logic                      we,
  output logic [BTB_INDEX_BITS-1:0] index,
  output btb_entry_t                wdata,
  input  btb_entry_t                rdata
);

  // Deferred update
  logic     pend_valid;
  word_t    pend_pc;
  logic     pend_taken;
  word_t    pend_target;

  // Update whose entry read is back this cycle
  logic     rmw_valid;
  word_t    rmw_pc;
  logic     rmw_taken;
  word_t    rmw_target;
  btb_tag_t rmw_tag;

  logic     lk_refused;
  logic     upd_req;
  logic     lk_req;
  logic     start_pend;
  logic     start_new;
  logic     lk_win;
  logic     store_pend;
  word_t    start_pc;
  logic     start_taken;
  word_t    start_target;
  logic     hit;
  logic     do_write;

  assign upd_req = upd.req && upd.we;
  assign lk_req  = lk.req && !lk.we;

  // The write half of a read-modify-write owns the port. The pending update goes first,
  // then a lookup that lost last cycle, then a new update
  assign start_pend = !rmw_valid && pend_valid;
  assign lk_win     = !rmw_valid && !pend_valid && lk_req && (lk_refused || !upd_req);
  assign start_new  = !rmw_valid && !pend_valid && upd_req && !lk_win;

  // A third update arriving while two are queued is dropped
  assign store_pend = upd_req && !start_new && (!pend_valid || start_pend);

  assign upd.gnt   = start_new;
  assign lk.gnt    = lk_win;
  assign upd.rdata = rdata;
  assign lk.rdata  = rdata;

  assign start_pc     = start_pend ? pend_pc : upd.pc;
  assign start_taken  = start_pend ? pend_taken : upd.taken;
  assign start_target = start_pend ? pend_target : upd.target;

  assign rmw_tag  = btb_tag(rmw_pc, BTB_INDEX_BITS);
  assign hit      = rdata.valid && (rdata.tag == rmw_tag);
  // Miss and not taken leaves the entry alone
  assign do_write = hit || rmw_taken;

  always_comb begin
    wdata.valid  = 1'b1;
    wdata.tag    = rmw_tag;
    wdata.target = rmw_taken ? rmw_target : rdata.target;
    if (!hit) begin
      wdata.ctr = CTR_ALLOC;
    end else if (rmw_taken) begin
      wdata.ctr = (rdata.ctr == 2'd3) ? 2'd3 : rdata.ctr + 2'd1;
    end else begin
      wdata.ctr = (rdata.ctr == 2'd0) ? 2'd0 : rdata.ctr - 2'd1;
    end
  end

  always_comb begin
    en    = 1'b0;
    we    = 1'b0;
    index = '0;
    if (rmw_valid) begin
      en    = do_write;
      we    = 1'b1;
      index = rmw_pc[BTB_INDEX_BITS+1:2];
    end else if (start_pend || start_new) begin
      en    = 1'b1;
      index = start_pc[BTB_INDEX_BITS+1:2];
    end else if (lk_win) begin
      en    = 1'b1;
      index = lk.pc[BTB_INDEX_BITS+1:2];
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pend_valid <= 1'b0;
      rmw_valid  <= 1'b0;
      lk_refused <= 1'b0;
    end else begin
      if (store_pend) begin
        pend_valid <= 1'b1;
      end else if (start_pend) begin
        pend_valid <= 1'b0;
      end
      rmw_valid  <= start_pend || start_new;
      lk_refused <= lk_req && !lk_win;
    end
  end

  always_ff @(posedge CLK) begin
    if (store_pend) begin
      pend_pc     <= upd.pc;
      pend_taken  <= upd.taken;
      pend_target <= upd.target;
    end
    if (start_pend || start_new) begin
      rmw_pc     <= start_pc;
      rmw_taken  <= start_taken;
      rmw_target <= start_target;
    end
  end

endmodule

//--- hw/btb_table.sv
module btb_table
  import branch_pkg::*;
#(
  parameter int BTB_INDEX_BITS = BTB_DEF_INDEX_BITS
) (
  input  logic                      CLK,
  input  logic                      nRST,
  input  logic                      en,
  input  logic                      we,
  input  logic [BTB_INDEX_BITS-1:0] index,
  input  btb_entry_t                wdata,
  output btb_entry_t                rdata
);

  localparam int ENTRIES  = 1 << BTB_INDEX_BITS;
  localparam int TAG_BITS = 30 - BTB_INDEX_BITS;

  logic [ENTRIES-1:0]  valid_q;
  logic [TAG_BITS-1:0] tag_mem [ENTRIES];
  word_t               target_mem [ENTRIES];
  counter_t            ctr_mem [ENTRIES];

  // Registered read port
  logic                rd_valid;
  logic [TAG_BITS-1:0] rd_tag;
  word_t               rd_target;
  counter_t            rd_ctr;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid_q  <= '0;
      rd_valid <= 1'b0;
    end else if (en) begin
      if (we) begin
        valid_q[index] <= wdata.valid;
      end else begin
        rd_valid <= valid_q[index];
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (en) begin
      if (we) begin
        tag_mem[index]    <= wdata.tag[TAG_BITS-1:0];
        target_mem[index] <= wdata.target;
        ctr_mem[index]    <= wdata.ctr;
      end else begin
        rd_tag    <= tag_mem[index];
        rd_target <= target_mem[index];
        rd_ctr    <= ctr_mem[index];
      end
    end
  end

  // Stored tag widened back to the entry layout
  assign rdata.valid  = rd_valid;
  assign rdata.tag    = btb_tag_t'(rd_tag);
  assign rdata.target = rd_target;
  assign rdata.ctr    = rd_ctr;

endmodule

//--- hw/branch_unit_top.sv
module branch_unit_top
  import branch_pkg::*;
#(
  parameter int BTB_INDEX_BITS = BTB_DEF_INDEX_BITS
) (
  input  logic         CLK,
  input  logic         nRST,
  input  logic         enable,
  input  jump_type_t   j_type,
  input  branch_type_t branch_type,
  input  word_t        reg_a,
  input  word_t        reg_b,
  input  word_t        imm,
  input  word_t        current_pc,
  input  logic         predicted_outcome,
  input  logic         fetch_req,
  input  word_t        fetch_pc,
  output logic         branch_outcome,
  output logic         miss,
  output word_t        correct_pc,
  output word_t        branch_target,
  output logic         resolved,
  output word_t        jump_wdat,
  output logic         pred_valid,
  output logic         pred_taken,
  output word_t        pred_target
);

  logic                      tbl_en;
  logic                      tbl_we;
  logic [BTB_INDEX_BITS-1:0] tbl_index;
  btb_entry_t                tbl_wdata;
  btb_entry_t                tbl_rdata;

  fu_branch_if fubif ();
  btb_port_if  upd ();
  btb_port_if  lk ();

  assign fubif.enable            = enable;
  assign fubif.j_type            = j_type;
  assign fubif.branch_type       = branch_type;
  assign fubif.reg_a             = reg_a;
  assign fubif.reg_b             = reg_b;
  assign fubif.imm               = imm;
  assign fubif.current_pc        = current_pc;
  assign fubif.predicted_outcome = predicted_outcome;

  assign branch_outcome = fubif.branch_outcome;
  assign miss           = fubif.miss;
  assign correct_pc     = fubif.correct_pc;
  assign branch_target  = fubif.branch_target;
  assign resolved       = fubif.resolved;
  assign jump_wdat      = fubif.jump_wdat;

  // Update strobe becomes a write request, the branch unit never waits on gnt
  assign upd.req    = fubif.update_btb;
  assign upd.we     = 1'b1;
  assign upd.pc     = fubif.update_pc;
  assign upd.taken  = fubif.branch_outcome;
  assign upd.target = fubif.branch_target;

  fu_branch fu_branch_inst (
    .CLK  (CLK),
    .nRST (nRST),
    .fubif(fubif)
  );

  btb_lookup #(
    .BTB_INDEX_BITS(BTB_INDEX_BITS)
  ) btb_lookup_inst (
    .CLK        (CLK),
    .nRST       (nRST),
    .fetch_req  (fetch_req),
    .fetch_pc   (fetch_pc),
    .lk         (lk),
    .pred_valid (pred_valid),
    .pred_taken (pred_taken),
    .pred_target(pred_target)
  );

  btb_arbiter #(
    .BTB_INDEX_BITS(BTB_INDEX_BITS)
  ) btb_arbiter_inst (
    .CLK  (CLK),
    .nRST (nRST),
    .upd  (upd),
    .lk   (lk),
    .en   (tbl_en),
    .we   (tbl_we),
    .index(tbl_index),
    .wdata(tbl_wdata),
    .rdata(tbl_rdata)
  );

  btb_table #(
    .BTB_INDEX_BITS(BTB_INDEX_BITS)
  ) btb_table_inst (
    .CLK  (CLK),
    .nRST (nRST),
    .en   (tbl_en),
    .we   (tbl_we),
    .index(tbl_index),
    .wdata(tbl_wdata),
    .rdata(tbl_rdata)
  );

endmodule

//--- tb/branch_unit_chk.sv
module branch_unit_chk
  import branch_pkg::*;
#(
  parameter int INDEX_BITS = BTB_DEF_INDEX_BITS
) (
  input logic                  CLK,
  input logic                  nRST,
  input logic                  upd_gnt,
  input logic                  lk_gnt,
  input logic                  pend_valid,
  input logic                  rmw_valid,
  input word_t                 pend_pc,
  input logic                  tbl_we,
  input logic [INDEX_BITS-1:0] tbl_index,
  input logic                  strobe,
  input word_t                 strobe_pc
);

  // Single BTB port
  a_one_grant: assert property (@(posedge CLK) disable iff (!nRST) !(upd_gnt && lk_gnt))
    else $error("update and lookup granted in the same cycle");

  // Deferred update lands in its own entry one cycle after it starts
  a_pend_drains: assert property (@(posedge CLK) disable iff (!nRST)
    pend_valid && !rmw_valid |=> tbl_we && (tbl_index == $past(pend_pc[INDEX_BITS+1:2])))
    else $error("pending update not written in the next cycle");

  a_one_strobe: assert property (@(posedge CLK) disable iff (!nRST)
    strobe |=> !(strobe && strobe_pc == $past(strobe_pc)))
    else $error("update strobe held for two cycles at one PC");

endmodule

bind btb_arbiter branch_unit_chk #(
  .INDEX_BITS(BTB_INDEX_BITS)
) arb_chk (
  .CLK(CLK), .nRST(nRST), .upd_gnt(upd.gnt), .lk_gnt(lk.gnt),
  .pend_valid(pend_valid), .rmw_valid(rmw_valid), .pend_pc(pend_pc),
  .tbl_we(we), .tbl_index(index), .strobe(1'b0), .strobe_pc(32'd0)
);

bind fu_branch branch_unit_chk strobe_chk (
  .CLK(CLK), .nRST(nRST), .upd_gnt(1'b0), .lk_gnt(1'b0), .pend_valid(1'b0),
  .rmw_valid(1'b0), .pend_pc(32'd0), .tbl_we(1'b0), .tbl_index('0),
  .strobe(fubif.update_btb), .strobe_pc(fubif.update_pc)
);

//--- tb/branch_unit_tb.sv
module branch_unit_tb
  import branch_pkg::*;
();

  // One table row, either an issued branch/jump or a fetch lookup
  typedef struct packed {
    logic         is_fetch;
    jump_type_t   jt;
    branch_type_t bt;
    word_t        a;
    word_t        b;
    word_t        imm;
    word_t        pc;
    logic         pred;
    int           hold;
    int           idle;
    logic         exp_outcome;
    logic         exp_miss;
    word_t        exp_pc;
    word_t        exp_target;
    word_t        exp_wdat;
    logic         exp_taken;
  } row_t;

  logic         CLK = 1'b0;
  logic         nRST;
  logic         enable;
  jump_type_t   j_type;
  branch_type_t branch_type;
  word_t        reg_a;
  word_t        reg_b;
  word_t        imm;
  word_t        current_pc;
  logic         predicted_outcome;
  logic         fetch_req;
  word_t        fetch_pc;
  logic         branch_outcome;
  logic         miss;
  word_t        correct_pc;
  word_t        branch_target;
  logic         resolved;
  word_t        jump_wdat;
  logic         pred_valid;
  logic         pred_taken;
  word_t        pred_target;

  row_t   rows[$];
  string  names[$];
  integer seed = 32'h1cd0_7b1c;
  int     errors = 0;
  int     cycle_count = 0;
  int     limit = 0;

  always #2 CLK = ~CLK;

  branch_unit_top #(
    .BTB_INDEX_BITS(4)
  ) branch_unit_top_inst (
    .CLK(CLK), .nRST(nRST), .enable(enable), .j_type(j_type),
    .branch_type(branch_type), .reg_a(reg_a), .reg_b(reg_b), .imm(imm),
    .current_pc(current_pc), .predicted_outcome(predicted_outcome),
    .fetch_req(fetch_req), .fetch_pc(fetch_pc), .branch_outcome(branch_outcome),
    .miss(miss), .correct_pc(correct_pc), .branch_target(branch_target),
    .resolved(resolved), .jump_wdat(jump_wdat), .pred_valid(pred_valid),
    .pred_taken(pred_taken), .pred_target(pred_target)
  );

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (limit > 0 && cycle_count >= limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("Testbench failed");
      $fatal(1, "cycle limit reached");
    end
  end

  task automatic check_value(string test, string field, word_t exp, word_t act);
    if (exp !== act) begin
      errors++;
      $display("mismatch %s %s: expected %h actual %h", test, field, exp, act);
      $display("Testbench failed");
      $fatal(1, "stopped at first wrong value");
    end
  endtask

  // Architectural compare rules
  function automatic logic expect_taken(branch_type_t bt, word_t a, word_t b);
    case (bt)
      BT_BEQ:  return a == b;
      BT_BNE:  return a != b;
      BT_BLT:  return $signed(a) < $signed(b);
      BT_BGE:  return $signed(a) >= $signed(b);
      BT_BLTU: return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic branch_row(string name, branch_type_t bt, word_t a, word_t b, word_t off,
                            word_t pc, logic pred, int hold, int idle);
    row_t r;
    r = '0;
    r.jt = J_NONE;
    r.bt = bt;
    r.a = a;
    r.b = b;
    r.imm = off;
    r.pc = pc;
    r.pred = pred;
    r.hold = hold;
    r.idle = idle;
    r.exp_outcome = expect_taken(bt, a, b);
    r.exp_miss = (r.exp_outcome != pred);
    r.exp_pc = r.exp_outcome ? pc + off : pc + 32'd4;
    // Branch target is pc plus offset whether or not it is taken
    r.exp_target = pc + off;
    rows.push_back(r);
    names.push_back(name);
  endtask

  task automatic jump_row(string name, jump_type_t jt, word_t a, word_t off, word_t pc);
    row_t r;
    r = '0;
    r.jt = jt;
    r.bt = BT_BEQ;
    r.a = a;
    r.imm = off;
    r.pc = pc;
    r.hold = 1;
    r.idle = 1;
    r.exp_outcome = 1'b1;
    r.exp_pc = (jt == J_JAL) ? pc + off : (a + off) & 32'hffff_fffe;
    r.exp_target = r.exp_pc;
    r.exp_wdat = pc + 32'd4;
    rows.push_back(r);
    names.push_back(name);
  endtask

  task automatic fetch_row(string name, word_t pc, logic taken, word_t target);
    row_t r;
    r = '0;
    r.is_fetch = 1'b1;
    r.jt = J_NONE;
    r.bt = BT_BEQ;
    r.pc = pc;
    r.idle = 1;
    r.exp_taken = taken;
    r.exp_pc = target;
    rows.push_back(r);
    names.push_back(name);
  endtask

  task automatic build_table();
    branch_type_t types[6];
    word_t        a;
    word_t        b;
    word_t        rnd;
    types = '{BT_BEQ, BT_BNE, BT_BLT, BT_BGE, BT_BLTU, BT_BGEU};
    // Compare rows live at BTB indexes 0 to 7
    for (int k = 0; k < 6; k++) begin
      a = (k < 2) ? 32'hffff_ffff : 32'h8000_0000;
      b = (k < 2) ? 32'hffff_ffff : 32'h7fff_ffff;
      branch_row($sformatf("%s_edge", types[k].name()), types[k], a, b, 32'h0000_0100,
                 32'h2000 + 32'((2 * k) % 8) * 4, k[0], 1, 1);
      rnd = $random(seed);
      a = $random(seed);
      b = rnd[0] ? a : $random(seed);
      branch_row($sformatf("%s_rand", types[k].name()), types[k], a, b, $random(seed),
                 32'h2000 + 32'((2 * k + 1) % 8) * 4, rnd[1], 1, 1);
    end
    jump_row("jal", J_JAL, 32'h0, 32'h0000_0100, 32'h0000_3000);
    jump_row("jalr", J_JALR, 32'h0000_4001, 32'h0000_0022, 32'h0000_3010);
    // Taken branch at index 8, then a hit and a tag miss on the same index
    branch_row("alloc_taken", BT_BEQ, 32'd5, 32'd5, 32'h40, 32'h1020, 1'b0, 1, 4);
    fetch_row("fetch_hit", 32'h1020, 1'b1, 32'h1060);
    fetch_row("fetch_unknown", 32'h1060, 1'b0, 32'h1064);
    // Counter goes 2, 3, 3, 2, 1, 0
    branch_row("sat_up_0", BT_BEQ, 32'd7, 32'd7, 32'h40, 32'h1020, 1'b1, 1, 1);
    branch_row("sat_up_1", BT_BEQ, 32'd7, 32'd7, 32'h40, 32'h1020, 1'b1, 1, 1);
    branch_row("sat_down_0", BT_BNE, 32'd7, 32'd7, 32'h40, 32'h1020, 1'b1, 1, 1);
    branch_row("sat_down_1", BT_BNE, 32'd7, 32'd7, 32'h40, 32'h1020, 1'b0, 1, 1);
    branch_row("sat_down_2", BT_BNE, 32'd7, 32'd7, 32'h40, 32'h1020, 1'b0, 1, 4);
    fetch_row("fetch_saturated", 32'h1020, 1'b0, 32'h1024);
    // Held branch must allocate once only
    branch_row("held_taken", BT_BEQ, 32'd1, 32'd1, 32'h80, 32'h1028, 1'b0, 3, 1);
    branch_row("held_not_taken", BT_BNE, 32'd1, 32'd1, 32'h80, 32'h1028, 1'b0, 1, 4);
    fetch_row("fetch_held", 32'h1028, 1'b0, 32'h102c);
  endtask

  task automatic apply_issue(int i);
    row_t r;
    r = rows[i];
    @(posedge CLK);
    #1;
    enable = 1'b1;
    j_type = r.jt;
    branch_type = r.bt;
    reg_a = r.a;
    reg_b = r.b;
    imm = r.imm;
    current_pc = r.pc;
    predicted_outcome = r.pred;
    @(negedge CLK);
    check_value(names[i], "branch_outcome", 32'(r.exp_outcome), 32'(branch_outcome));
    check_value(names[i], "miss", 32'(r.exp_miss), 32'(miss));
    check_value(names[i], "resolved", 32'(!r.exp_miss), 32'(resolved));
    check_value(names[i], "correct_pc", r.exp_pc, correct_pc);
    check_value(names[i], "branch_target", r.exp_target, branch_target);
    if (r.jt != J_NONE) begin
      check_value(names[i], "jump_wdat", r.exp_wdat, jump_wdat);
    end
    repeat (r.hold - 1) @(posedge CLK);
    @(posedge CLK);
    #1;
    enable = 1'b0;
    repeat (r.idle) @(posedge CLK);
  endtask

  task automatic apply_fetch(int i);
    row_t r;
    r = rows[i];
    @(posedge CLK);
    #1;
    fetch_req = 1'b1;
    fetch_pc = r.pc;
    @(posedge CLK);
    #1;
    fetch_req = 1'b0;
    @(negedge CLK);
    while (!pred_valid) @(negedge CLK);
    check_value(names[i], "pred_taken", 32'(r.exp_taken), 32'(pred_taken));
    check_value(names[i], "pred_target", r.exp_pc, pred_target);
    repeat (r.idle) @(posedge CLK);
  endtask

  initial begin
    nRST = 1'b0;
    enable = 1'b0;
    j_type = J_NONE;
    branch_type = BT_BEQ;
    reg_a = '0;
    reg_b = '0;
    imm = '0;
    current_pc = '0;
    predicted_outcome = 1'b0;
    fetch_req = 1'b0;
    fetch_pc = '0;
    build_table();
    limit = rows.size() * 8 + 50;
    repeat (3) @(posedge CLK);
    #1;
    nRST = 1'b1;
    @(negedge CLK);
    check_value("reset", "pred_valid", 32'd0, 32'(pred_valid));
    foreach (rows[i]) begin
      if (rows[i].is_fetch) begin
        apply_fetch(i);
      end else begin
        apply_issue(i);
      end
    end
    @(posedge CLK);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
hw/branch_pkg.sv
hw/fu_branch_if.sv
hw/btb_port_if.sv
hw/fu_branch.sv
hw/btb_lookup.sv
hw/btb_arbiter.sv
hw/btb_table.sv
hw/branch_unit_top.sv
tb/branch_unit_chk.sv
tb/branch_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= branch_unit_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
